//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert -f all.f --top-module tb_data_cache_complex -o sim_tb
	./obj_dir/sim_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q "test passed" sim.log && ! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
+incdir+hdl
hdl/dcache_pkg.sv
hdl/cache_array.sv
hdl/load_controller.sv
hdl/store_controller.sv
hdl/port_arbiter.sv
hdl/data_cache_complex.sv
test/data_cache_complex_chk.sv
test/tb_data_cache_complex.sv

//--- hdl/cache_array.sv
`default_nettype none

`include "dcache_params.svh"

module cache_array (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire dcache_pkg::data_word_t  load_lookup_addr_i,
    input  wire dcache_pkg::data_word_t  store_lookup_addr_i,
    input  wire logic                    write_i,
    input  wire dcache_pkg::cache_write_t write_entry_i,
    output dcache_pkg::lookup_t          load_lookup_o,
    output dcache_pkg::lookup_t          store_lookup_o
);

    localparam int LINES = 2 ** `DCACHE_INDEX_BITS;
    localparam int WORDS = LINES * `DCACHE_BLOCK_WORDS;

    dcache_pkg::tag_t       tag_mem  [LINES];
    dcache_pkg::data_word_t data_mem [WORDS];
    logic [LINES-1:0]       valid_q;
    logic [LINES-1:0]       dirty_q;

    // One read port, evaluated against the array before this cycle's write.
    function automatic dcache_pkg::lookup_t read_port(input dcache_pkg::data_word_t addr);
        dcache_pkg::index_t  idx;
        dcache_pkg::offset_t off;
        dcache_pkg::lookup_t result;
        idx          = addr[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS];
        off          = addr[2 +: `DCACHE_OFFSET_BITS];
        result.tag   = tag_mem[idx];
        result.data  = data_mem[{idx, off}];
        result.hit   = valid_q[idx] && (tag_mem[idx] == addr[31 -: `DCACHE_TAG_BITS]);
        result.dirty = valid_q[idx] && dirty_q[idx];
        return result;
    endfunction

    always_ff @(posedge clk_i) begin
        if (write_i) begin
            for (int b = 0; b < 4; b++) begin
                if (write_entry_i.mask[b]) begin
                    data_mem[{write_entry_i.index, write_entry_i.offset}][8*b +: 8]
                        <= write_entry_i.data[8*b +: 8];
                end
            end
            if (write_entry_i.update_status) begin
                tag_mem[write_entry_i.index] <= write_entry_i.tag;
            end
        end
        load_lookup_o  <= read_port(load_lookup_addr_i);
        store_lookup_o <= read_port(store_lookup_addr_i);
    end

    // Line status.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (write_i && write_entry_i.update_status) begin
            valid_q[write_entry_i.index] <= write_entry_i.valid;
            dirty_q[write_entry_i.index] <= write_entry_i.dirty;
        end
    end

endmodule

`default_nettype wire

//--- hdl/data_cache_complex.sv
`default_nettype none

module data_cache_complex (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     load_request_i,
    input  wire dcache_pkg::data_word_t   load_address_i,
    output dcache_pkg::data_word_t        load_data_o,
    output logic                          load_valid_o,
    input  wire logic                     store_request_i,
    input  wire dcache_pkg::store_entry_t store_entry_i,
    output logic                          store_valid_o,
    output logic                          mem_load_req_o,
    output dcache_pkg::data_word_t        mem_load_addr_o,
    input  wire logic                     mem_load_valid_i,
    input  wire dcache_pkg::data_word_t   mem_load_data_i,
    output logic                          mem_store_req_o,
    output dcache_pkg::mem_store_t        mem_store_o,
    input  wire logic                     mem_store_done_i
);

    dcache_pkg::data_word_t   load_lookup_addr;
    dcache_pkg::data_word_t   store_lookup_addr;
    dcache_pkg::lookup_t      load_lookup;
    dcache_pkg::lookup_t      store_lookup;
    logic                     cache_write;
    dcache_pkg::cache_write_t cache_write_data;

    logic                     load_write;
    dcache_pkg::cache_write_t load_write_data;
    logic                     load_mem_req;
    dcache_pkg::mem_store_t   load_mem;
    logic                     load_done;

    logic                     store_write;
    dcache_pkg::cache_write_t store_write_data;
    logic                     store_mem_req;
    dcache_pkg::mem_store_t   store_mem;
    logic                     store_done;
    logic                     store_halt;

    cache_array cache_array_i (
        .clk_i               ( clk_i             ),
        .rst_i               ( rst_i             ),
        .load_lookup_addr_i  ( load_lookup_addr  ),
        .store_lookup_addr_i ( store_lookup_addr ),
        .write_i             ( cache_write       ),
        .write_entry_i       ( cache_write_data  ),
        .load_lookup_o       ( load_lookup       ),
        .store_lookup_o      ( store_lookup      )
    );

    load_controller load_controller_i (
        .clk_i              ( clk_i            ),
        .rst_i              ( rst_i            ),
        .request_i          ( load_request_i   ),
        .address_i          ( load_address_i   ),
        .lookup_i           ( load_lookup      ),
        .mem_load_valid_i   ( mem_load_valid_i ),
        .mem_load_data_i    ( mem_load_data_i  ),
        .mem_store_done_i   ( load_done        ),
        .data_o             ( load_data_o      ),
        .valid_o            ( load_valid_o     ),
        .lookup_addr_o      ( load_lookup_addr ),
        .cache_write_o      ( load_write       ),
        .cache_write_data_o ( load_write_data  ),
        .mem_load_req_o     ( mem_load_req_o   ),
        .mem_load_addr_o    ( mem_load_addr_o  ),
        .mem_store_req_o    ( load_mem_req     ),
        .mem_store_o        ( load_mem         )
    );

    store_controller store_controller_i (
        .clk_i              ( clk_i             ),
        .rst_i              ( rst_i             ),
        .halt_i             ( store_halt        ),
        .request_i          ( store_request_i   ),
        .entry_i            ( store_entry_i     ),
        .lookup_i           ( store_lookup      ),
        .mem_store_done_i   ( store_done        ),
        .valid_o            ( store_valid_o     ),
        .lookup_addr_o      ( store_lookup_addr ),
        .cache_write_o      ( store_write       ),
        .cache_write_data_o ( store_write_data  ),
        .mem_store_req_o    ( store_mem_req     ),
        .mem_store_o        ( store_mem         )
    );

    port_arbiter port_arbiter_i (
        .load_write_i       ( load_write       ),
        .load_write_data_i  ( load_write_data  ),
        .store_write_i      ( store_write      ),
        .store_write_data_i ( store_write_data ),
        .load_mem_req_i     ( load_mem_req     ),
        .load_mem_i         ( load_mem         ),
        .store_mem_req_i    ( store_mem_req    ),
        .store_mem_i        ( store_mem        ),
        .mem_store_done_i   ( mem_store_done_i ),
        .write_o            ( cache_write      ),
        .write_data_o       ( cache_write_data ),
        .mem_store_req_o    ( mem_store_req_o  ),
        .mem_store_o        ( mem_store_o      ),
        .load_done_o        ( load_done        ),
        .store_done_o       ( store_done       ),
        .store_halt_o       ( store_halt       )
    );

endmodule

`default_nettype wire

//--- hdl/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// Total capacity in bytes, small enough that random traffic evicts lines.
`define DCACHE_SIZE_BYTES 1024

// Words in one block.
`define DCACHE_BLOCK_WORDS 4

// Address layout is tag, index, word offset, then two byte-select bits.
`define DCACHE_OFFSET_BITS $clog2(`DCACHE_BLOCK_WORDS)
`define DCACHE_INDEX_BITS $clog2(`DCACHE_SIZE_BYTES / (`DCACHE_BLOCK_WORDS * 4))
`define DCACHE_TAG_BITS (32 - 2 - `DCACHE_OFFSET_BITS - `DCACHE_INDEX_BITS)

// Bit position of the lowest index bit.
`define DCACHE_INDEX_LSB (2 + `DCACHE_OFFSET_BITS)

`endif

//--- hdl/dcache_pkg.sv
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [31:0] data_word_t;
    typedef logic [`DCACHE_TAG_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [`DCACHE_OFFSET_BITS-1:0] offset_t;
    typedef logic [3:0] byte_mask_t;

    typedef struct packed {
        data_word_t address;
        data_word_t data;
        byte_mask_t mask;
    } store_entry_t;

    typedef struct packed {
        data_word_t address;
        data_word_t data;
        byte_mask_t mask;
    } mem_store_t;

    // Tag and status are written only when update_status is set.
    typedef struct packed {
        index_t     index;
        offset_t    offset;
        data_word_t data;
        byte_mask_t mask;
        tag_t       tag;
        logic       valid;
        logic       dirty;
        logic       update_status;
    } cache_write_t;

    typedef struct packed {
        tag_t       tag;
        data_word_t data;
        logic       hit;
        logic       dirty;
    } lookup_t;

    typedef enum logic [2:0] {
        LOAD_IDLE,
        LOAD_LOOKUP,
        LOAD_WRITEBACK,
        LOAD_FILL,
        LOAD_FINISH
    } load_state_t;

    typedef enum logic [1:0] {
        STORE_IDLE,
        STORE_LOOKUP,
        STORE_MERGE,
        STORE_WRITE_THROUGH
    } store_state_t;

endpackage

`default_nettype wire

//--- hdl/load_controller.sv
`default_nettype none

`include "dcache_params.svh"

module load_controller (
    input  wire logic                    clk_i,
    input  wire logic                    rst_i,
    input  wire logic                    request_i,
    input  wire dcache_pkg::data_word_t  address_i,
    input  wire dcache_pkg::lookup_t     lookup_i,
    input  wire logic                    mem_load_valid_i,
    input  wire dcache_pkg::data_word_t  mem_load_data_i,
    input  wire logic                    mem_store_done_i,
    output dcache_pkg::data_word_t       data_o,
    output logic                         valid_o,
    output dcache_pkg::data_word_t       lookup_addr_o,
    output logic                         cache_write_o,
    output dcache_pkg::cache_write_t     cache_write_data_o,
    output logic                         mem_load_req_o,
    output dcache_pkg::data_word_t       mem_load_addr_o,
    output logic                         mem_store_req_o,
    output dcache_pkg::mem_store_t       mem_store_o
);

    dcache_pkg::load_state_t state;
    dcache_pkg::data_word_t  addr_q;
    dcache_pkg::tag_t        victim_tag;
    dcache_pkg::offset_t     cnt;
    dcache_pkg::data_word_t  block_addr;
    dcache_pkg::offset_t     req_offset;
    dcache_pkg::offset_t     wb_offset;
    logic                    fill_beat;

    // Word of the requested block selected by the beat counter.
    assign block_addr = {addr_q[31:`DCACHE_INDEX_LSB], cnt, 2'b00};
    assign req_offset = addr_q[2 +: `DCACHE_OFFSET_BITS];
    assign wb_offset  = mem_store_o.address[2 +: `DCACHE_OFFSET_BITS];
    assign fill_beat  = (state == dcache_pkg::LOAD_FILL) && mem_load_req_o && mem_load_valid_i;

    assign lookup_addr_o   = (state == dcache_pkg::LOAD_IDLE) ? address_i : block_addr;
    assign mem_load_addr_o = block_addr;
    assign valid_o         = (state == dcache_pkg::LOAD_FINISH);

    // Each fill beat lands in the cache; the last one sets tag and valid.
    assign cache_write_o                    = fill_beat;
    assign cache_write_data_o.index         = addr_q[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS];
    assign cache_write_data_o.offset        = cnt;
    assign cache_write_data_o.data          = mem_load_data_i;
    assign cache_write_data_o.mask          = 4'hf;
    assign cache_write_data_o.tag           = addr_q[31 -: `DCACHE_TAG_BITS];
    assign cache_write_data_o.valid         = 1'b1;
    assign cache_write_data_o.dirty         = 1'b0;
    assign cache_write_data_o.update_status = (cnt == '1);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state           <= dcache_pkg::LOAD_IDLE;
            cnt             <= '0;
            mem_load_req_o  <= 1'b0;
            mem_store_req_o <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::LOAD_IDLE: begin
                    if (request_i) begin
                        state <= dcache_pkg::LOAD_LOOKUP;
                        cnt   <= '0;
                    end
                end
                dcache_pkg::LOAD_LOOKUP: begin
                    if (lookup_i.hit) begin
                        state <= dcache_pkg::LOAD_FINISH;
                    end else if (lookup_i.dirty) begin
                        state <= dcache_pkg::LOAD_WRITEBACK;
                    end else begin
                        state <= dcache_pkg::LOAD_FILL;
                    end
                end
                dcache_pkg::LOAD_WRITEBACK: begin
                    // The counter moves on at issue so the next word is read
                    // while memory is still busy with this one.
                    if (!mem_store_req_o) begin
                        mem_store_req_o <= 1'b1;
                        cnt             <= cnt + 1'b1;
                    end else if (mem_store_done_i) begin
                        mem_store_req_o <= 1'b0;
                        if (wb_offset == '1) begin
                            state <= dcache_pkg::LOAD_FILL;
                        end
                    end
                end
                dcache_pkg::LOAD_FILL: begin
                    if (!mem_load_req_o) begin
                        mem_load_req_o <= 1'b1;
                    end else if (mem_load_valid_i) begin
                        mem_load_req_o <= 1'b0;
                        cnt            <= cnt + 1'b1;
                        if (cnt == '1) begin
                            state <= dcache_pkg::LOAD_FINISH;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::LOAD_IDLE;
                end
            endcase
        end
    end

    // Request address, victim word and returned data.
    always_ff @(posedge clk_i) begin
        if (state == dcache_pkg::LOAD_IDLE && request_i) begin
            addr_q <= address_i;
        end
        if (state == dcache_pkg::LOAD_LOOKUP) begin
            victim_tag <= lookup_i.tag;
            data_o     <= lookup_i.data;
        end
        if (state == dcache_pkg::LOAD_WRITEBACK && !mem_store_req_o) begin
            mem_store_o.address <= {victim_tag, addr_q[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS],
                                    cnt, 2'b00};
            mem_store_o.data    <= lookup_i.data;
            mem_store_o.mask    <= 4'hf;
        end
        if (fill_beat && cnt == req_offset) begin
            data_o <= mem_load_data_i;
        end
    end

endmodule

`default_nettype wire

//--- hdl/port_arbiter.sv
`default_nettype none

module port_arbiter (
    input  wire logic                     load_write_i,
    input  wire dcache_pkg::cache_write_t load_write_data_i,
    input  wire logic                     store_write_i,
    input  wire dcache_pkg::cache_write_t store_write_data_i,
    input  wire logic                     load_mem_req_i,
    input  wire dcache_pkg::mem_store_t   load_mem_i,
    input  wire logic                     store_mem_req_i,
    input  wire dcache_pkg::mem_store_t   store_mem_i,
    input  wire logic                     mem_store_done_i,
    output logic                          write_o,
    output dcache_pkg::cache_write_t      write_data_o,
    output logic                          mem_store_req_o,
    output dcache_pkg::mem_store_t        mem_store_o,
    output logic                          load_done_o,
    output logic                          store_done_o,
    output logic                          store_halt_o
);

    logic port_conflict;
    logic mem_conflict;

    // Cache write port, load first.
    assign write_o      = load_write_i | store_write_i;
    assign write_data_o = load_write_i ? load_write_data_i : store_write_data_i;

    // Memory store channel, load first.
    assign mem_store_req_o = load_mem_req_i | store_mem_req_i;
    assign mem_store_o     = load_mem_req_i ? load_mem_i : store_mem_i;

    // Done goes back to whichever request is being forwarded.
    assign load_done_o  = mem_store_done_i & load_mem_req_i;
    assign store_done_o = mem_store_done_i & store_mem_req_i & ~load_mem_req_i;

    assign port_conflict = load_write_i & store_write_i;
    assign mem_conflict  = load_mem_req_i & store_mem_req_i;
    assign store_halt_o  = port_conflict | mem_conflict;

endmodule

`default_nettype wire

//--- hdl/store_controller.sv
`default_nettype none

`include "dcache_params.svh"

module store_controller (
    input  wire logic                     clk_i,
    input  wire logic                     rst_i,
    input  wire logic                     halt_i,
    input  wire logic                     request_i,
    input  wire dcache_pkg::store_entry_t entry_i,
    input  wire dcache_pkg::lookup_t      lookup_i,
    input  wire logic                     mem_store_done_i,
    output logic                          valid_o,
    output dcache_pkg::data_word_t        lookup_addr_o,
    output logic                          cache_write_o,
    output dcache_pkg::cache_write_t      cache_write_data_o,
    output logic                          mem_store_req_o,
    output dcache_pkg::mem_store_t        mem_store_o
);

    dcache_pkg::store_state_t state;
    dcache_pkg::store_entry_t entry_q;

    assign lookup_addr_o = (state == dcache_pkg::STORE_IDLE) ? entry_i.address : entry_q.address;
    assign valid_o       = (state == dcache_pkg::STORE_MERGE);

    // A hit merges the masked bytes and marks the line dirty.
    assign cache_write_o                    = (state == dcache_pkg::STORE_LOOKUP) && lookup_i.hit;
    assign cache_write_data_o.index         = entry_q.address[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS];
    assign cache_write_data_o.offset        = entry_q.address[2 +: `DCACHE_OFFSET_BITS];
    assign cache_write_data_o.data          = entry_q.data;
    assign cache_write_data_o.mask          = entry_q.mask;
    assign cache_write_data_o.tag           = entry_q.address[31 -: `DCACHE_TAG_BITS];
    assign cache_write_data_o.valid         = 1'b1;
    assign cache_write_data_o.dirty         = 1'b1;
    assign cache_write_data_o.update_status = 1'b1;

    // Miss path, no allocation.
    assign mem_store_req_o     = (state == dcache_pkg::STORE_WRITE_THROUGH);
    assign mem_store_o.address = {entry_q.address[31:2], 2'b00};
    assign mem_store_o.data    = entry_q.data;
    assign mem_store_o.mask    = entry_q.mask;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= dcache_pkg::STORE_IDLE;
        end else if (!halt_i) begin
            case (state)
                dcache_pkg::STORE_IDLE: begin
                    if (request_i) begin
                        state <= dcache_pkg::STORE_LOOKUP;
                    end
                end
                dcache_pkg::STORE_LOOKUP: begin
                    if (lookup_i.hit) begin
                        state <= dcache_pkg::STORE_MERGE;
                    end else begin
                        state <= dcache_pkg::STORE_WRITE_THROUGH;
                    end
                end
                dcache_pkg::STORE_WRITE_THROUGH: begin
                    if (mem_store_done_i) begin
                        state <= dcache_pkg::STORE_MERGE;
                    end
                end
                default: begin
                    state <= dcache_pkg::STORE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == dcache_pkg::STORE_IDLE && request_i && !halt_i) begin
            entry_q <= entry_i;
        end
    end

endmodule

`default_nettype wire

//--- test/data_cache_complex_chk.sv
`default_nettype none

module data_cache_complex_chk (
    input wire logic                   clk_i,
    input wire logic                   rst_i,
    input wire logic                   mem_load_req_o,
    input wire dcache_pkg::data_word_t mem_load_addr_o,
    input wire logic                   mem_load_valid_i,
    input wire logic                   mem_store_req_o,
    input wire logic                   load_mem_req,
    input wire dcache_pkg::mem_store_t load_mem,
    input wire logic                   load_done,
    input wire logic                   store_mem_req,
    input wire dcache_pkg::mem_store_t store_mem,
    input wire logic                   store_done,
    input wire logic                   load_valid_o,
    input wire logic                   store_valid_o
);

    // Load channel request and address hold until valid.
    assert property (@(posedge clk_i) disable iff (rst_i)
        mem_load_req_o && !mem_load_valid_i |=> mem_load_req_o && $stable(mem_load_addr_o))
        else $error("memory load request changed before valid");

    // Each controller holds its own store request until its done.
    assert property (@(posedge clk_i) disable iff (rst_i)
        load_mem_req && !load_done |=> load_mem_req && $stable(load_mem))
        else $error("write-back request changed before done");

    assert property (@(posedge clk_i) disable iff (rst_i)
        store_mem_req && !store_done |=> store_mem_req && $stable(store_mem))
        else $error("write-through request changed before done");

    assert property (@(posedge clk_i) disable iff (rst_i) load_valid_o |=> !load_valid_o)
        else $error("load valid longer than one cycle");

    assert property (@(posedge clk_i) disable iff (rst_i) store_valid_o |=> !store_valid_o)
        else $error("store valid longer than one cycle");

    assert property (@(posedge clk_i)
        rst_i |=> !load_valid_o && !store_valid_o && !mem_load_req_o && !mem_store_req_o)
        else $error("strobe high after reset");

endmodule

bind data_cache_complex data_cache_complex_chk data_cache_complex_chk_i (
    .clk_i            ( clk_i            ),
    .rst_i            ( rst_i            ),
    .mem_load_req_o   ( mem_load_req_o   ),
    .mem_load_addr_o  ( mem_load_addr_o  ),
    .mem_load_valid_i ( mem_load_valid_i ),
    .mem_store_req_o  ( mem_store_req_o  ),
    .load_mem_req     ( load_mem_req     ),
    .load_mem         ( load_mem         ),
    .load_done        ( load_done        ),
    .store_mem_req    ( store_mem_req    ),
    .store_mem        ( store_mem        ),
    .store_done       ( store_done       ),
    .load_valid_o     ( load_valid_o     ),
    .store_valid_o    ( store_valid_o    )
);

`default_nettype wire

//--- test/tb_data_cache_complex.sv
`default_nettype none

`include "dcache_params.svh"

module tb_data_cache_complex;

    localparam int NUM_OPS   = 400;
    localparam int MAX_CYCLE = 40 * NUM_OPS;
    localparam int MEM_WORDS = 4096;
    localparam int LINES     = 2 ** `DCACHE_INDEX_BITS;

    logic                     clk_i = 1'b0;
    logic                     rst_i;
    logic                     load_request_i;
    dcache_pkg::data_word_t   load_address_i;
    dcache_pkg::data_word_t   load_data_o;
    logic                     load_valid_o;
    logic                     store_request_i;
    dcache_pkg::store_entry_t store_entry_i;
    logic                     store_valid_o;
    logic                     mem_load_req_o;
    dcache_pkg::data_word_t   mem_load_addr_o;
    logic                     mem_load_valid_i;
    dcache_pkg::data_word_t   mem_load_data_i;
    logic                     mem_store_req_o;
    dcache_pkg::mem_store_t   mem_store_o;
    logic                     mem_store_done_i;

    integer                 seed = 52361;
    int                     cycle_count = 0;
    dcache_pkg::data_word_t mem_model [MEM_WORDS];
    dcache_pkg::data_word_t gold [MEM_WORDS];
    dcache_pkg::tag_t       res_tag [LINES];
    logic [LINES-1:0]       res_valid;
    logic [LINES-1:0]       res_dirty;
    dcache_pkg::data_word_t wb_addr_q [$];
    dcache_pkg::mem_store_t wt_exp;
    logic                   ld_busy;
    int                     ld_wait;
    logic                   st_busy;
    int                     st_wait;

    data_cache_complex data_cache_complex_i (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLE) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLE);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed) & 32'h7fff_ffff;
        return r % n;
    endfunction

    function automatic dcache_pkg::data_word_t mask_bits(input dcache_pkg::byte_mask_t m);
        dcache_pkg::data_word_t bits;
        for (int b = 0; b < 4; b++) begin
            bits[8*b +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    function automatic logic is_resident(input dcache_pkg::data_word_t addr);
        return res_valid[addr[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS]] &&
               res_tag[addr[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS]] ==
               addr[31 -: `DCACHE_TAG_BITS];
    endfunction

    task automatic check_word(input string name, input dcache_pkg::data_word_t actual,
                              input dcache_pkg::data_word_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("test failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("test failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_mem_store(input string name, input dcache_pkg::mem_store_t actual,
                                   input dcache_pkg::mem_store_t expected);
        if (actual !== expected) begin
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
            $display("test failed");
            $fatal(1, "memory store mismatch");
        end
    endtask

    task automatic step();
        @(posedge clk_i);
        #1;
    endtask

    // Memory model. Each request is answered after 1 to 4 cycles.
    always begin
        dcache_pkg::mem_store_t seen;
        dcache_pkg::mem_store_t expected;
        dcache_pkg::data_word_t keep;
        step();
        if (mem_load_valid_i) begin
            mem_load_valid_i = 1'b0;
        end else if (ld_busy) begin
            if (ld_wait == 0) begin
                mem_load_data_i  = mem_model[mem_load_addr_o[13:2]];
                mem_load_valid_i = 1'b1;
                ld_busy          = 1'b0;
            end else begin
                ld_wait--;
            end
        end else if (!rst_i && mem_load_req_o) begin
            ld_busy = 1'b1;
            ld_wait = rand_below(4);
        end
        if (mem_store_done_i) begin
            mem_store_done_i = 1'b0;
        end else if (st_busy) begin
            if (st_wait == 0) begin
                // Either the next word of a write-back or the pending write-through.
                if (wb_addr_q.size() > 0 && mem_store_o.address == wb_addr_q[0]) begin
                    expected.address = wb_addr_q.pop_front();
                    expected.mask    = 4'hf;
                end else begin
                    expected = wt_exp;
                end
                expected.data    = gold[expected.address[13:2]] & mask_bits(expected.mask);
                seen             = mem_store_o;
                seen.data        = mem_store_o.data & mask_bits(mem_store_o.mask);
                check_mem_store("mem_store_o", seen, expected);
                keep             = mem_model[mem_store_o.address[13:2]] &
                                   ~mask_bits(mem_store_o.mask);
                mem_model[mem_store_o.address[13:2]] = keep | seen.data;
                mem_store_done_i = 1'b1;
                st_busy          = 1'b0;
            end else begin
                st_wait--;
            end
        end else if (!rst_i && mem_store_req_o) begin
            st_busy = 1'b1;
            st_wait = rand_below(4);
        end
    end

    task automatic run_load(input dcache_pkg::data_word_t addr, input logic timed);
        dcache_pkg::data_word_t expected;
        dcache_pkg::index_t     idx;
        logic                   was_hit;
        int                     cycles;
        idx       = addr[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS];
        expected  = gold[addr[13:2]];
        was_hit   = is_resident(addr);
        // A miss on a dirty line writes the old block back word by word.
        if (!was_hit && res_valid[idx] && res_dirty[idx]) begin
            for (int k = 0; k < `DCACHE_BLOCK_WORDS; k++) begin
                wb_addr_q.push_back({res_tag[idx], idx, k[`DCACHE_OFFSET_BITS-1:0], 2'b00});
            end
        end
        if (!was_hit) begin
            res_dirty[idx] = 1'b0;
        end
        res_valid[idx] = 1'b1;
        res_tag[idx]   = addr[31 -: `DCACHE_TAG_BITS];
        load_address_i = addr;
        load_request_i = 1'b1;
        step();
        load_request_i = 1'b0;
        cycles         = 1;
        while (!load_valid_o) begin
            step();
            cycles++;
        end
        check_word("load_data_o", load_data_o, expected);
        if (timed && was_hit) begin
            check_word("load hit latency", cycles, 2);
        end
        step();
    endtask

    task automatic run_store(input dcache_pkg::store_entry_t entry, input logic timed);
        dcache_pkg::index_t idx;
        logic               was_hit;
        int                 cycles;
        idx     = entry.address[`DCACHE_INDEX_LSB +: `DCACHE_INDEX_BITS];
        was_hit = is_resident(entry.address);
        if (was_hit) begin
            res_dirty[idx] = 1'b1;
        end else begin
            // A miss goes to memory with the store's own mask.
            wt_exp.address = {entry.address[31:2], 2'b00};
            wt_exp.mask    = entry.mask;
        end
        for (int b = 0; b < 4; b++) begin
            if (entry.mask[b]) begin
                gold[entry.address[13:2]][8*b +: 8] = entry.data[8*b +: 8];
            end
        end
        store_entry_i   = entry;
        store_request_i = 1'b1;
        step();
        store_request_i = 1'b0;
        cycles          = 1;
        while (!store_valid_o) begin
            step();
            cycles++;
        end
        // With no load outstanding a hit sees no halt.
        if (timed && was_hit) begin
            check_word("store hit latency", cycles, 2);
        end
        step();
    endtask

    initial begin
        dcache_pkg::data_word_t   addr;
        dcache_pkg::store_entry_t entry;
        int                       ops;
        int                       mode;
        rst_i            = 1'b1;
        load_request_i   = 1'b0;
        load_address_i   = '0;
        store_request_i  = 1'b0;
        store_entry_i    = '0;
        mem_load_valid_i = 1'b0;
        mem_load_data_i  = '0;
        mem_store_done_i = 1'b0;
        ld_busy          = 1'b0;
        ld_wait          = 0;
        st_busy          = 1'b0;
        st_wait          = 0;
        res_valid        = '0;
        res_dirty        = '0;
        wt_exp           = '0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            mem_model[w] = (w * 32'h9e37_79b1) ^ {w[15:0], 16'h5a3c};
            gold[w]      = mem_model[w];
        end
        repeat (5) step();
        rst_i = 1'b0;
        repeat (4) begin
            step();
            check_flag("load_valid_o", load_valid_o, 1'b0);
            check_flag("store_valid_o", store_valid_o, 1'b0);
            check_flag("mem_load_req_o", mem_load_req_o, 1'b0);
            check_flag("mem_store_req_o", mem_store_req_o, 1'b0);
        end
        ops = 0;
        while (ops < NUM_OPS) begin
            // Four tags per index keep hits and evictions frequent.
            mode          = rand_below(3);
            addr          = rand_below(1024) * 4;
            entry.address = rand_below(1024) * 4;
            entry.data    = $random(seed);
            entry.mask    = 4'(rand_below(15) + 1);
            if (mode == 0) begin
                run_load(addr, 1'b1);
                ops += 1;
            end else if (mode == 1) begin
                run_store(entry, 1'b1);
                ops += 1;
            end else begin
                if (entry.address[9:4] == addr[9:4]) begin
                    entry.address[4] = ~entry.address[4];
                end
                fork
                    run_load(addr, 1'b0);
                    run_store(entry, 1'b0);
                join
                ops += 2;
            end
        end
        if (wb_addr_q.size() != 0) begin
            $display("some expected write-back words never reached memory");
            $display("test failed");
            $fatal(1, "missing write-back");
        end
        // Blocks that are not cached must be up to date in memory.
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (!is_resident(w * 4)) begin
                check_word($sformatf("memory word %h", w * 4), mem_model[w], gold[w]);
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
